// ==== rtl/link_pkg.sv ====
// ##########################################################################
// shared definitions of the sampling link
// vector typedefs for sample, channel and serial payload
// sample and frame structs passed between the stages
// state enums of the four state machines, header tag constant
// ##########################################################################

package link_pkg;

	// converter result
	typedef logic [7:0] sample_t;
	// multiplexer channel, 8 inputs
	typedef logic [2:0] channel_t;
	// byte that goes out on the serial line
	typedef logic [7:0] frame_byte_t;

	// one converted sample with the channel it came from
	typedef struct packed {
		channel_t channel;
		sample_t  data;
	} sample_s;

	// one frame for the transmit buffer
	typedef struct packed {
		frame_byte_t payload;
		logic        is_header;
	} frame_s;

	// upper nibble of every header byte
	localparam logic [3:0] header_tag = 4'hA;

	typedef enum logic [2:0] {
		seq_mux_en, seq_settle, seq_start, seq_wait_busy, seq_wait_done, seq_rotate
	} seq_state_e;

	typedef enum logic [1:0] {disp_idle, disp_shoot, disp_wait_confirm, disp_gap} disp_state_e;

	typedef enum logic [1:0] {buf_idle, buf_load, buf_send, buf_wait_end} buf_state_e;

	typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

endpackage

// ==== rtl/adc_sequencer.sv ====
// ##########################################################################
// converter sequencer
// drives mux enable and start of conversion, waits for eoc,
// captures the byte and rotates through the 8 channels
// ##########################################################################
`timescale 1ns/1ps

module adc_sequencer (
	input  logic                clock,
	input  logic                rst,
	input  logic                eoc,
	input  link_pkg::sample_t   data_in,
	input  logic                rdy,
	output logic                mux_en,
	output logic                soc,
	output logic                load_dato,
	output logic [3:0]          canale,
	output link_pkg::sample_s   sample,
	output logic                send_data
);

	link_pkg::seq_state_e state;
	// channel being converted right now
	link_pkg::channel_t   chan;
	// dispatcher has raised rdy for the current sample
	logic                 rdy_seen;

	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= link_pkg::seq_mux_en;
			chan      <= '0;
			rdy_seen  <= 1'b0;
			mux_en    <= 1'b0;
			soc       <= 1'b0;
			load_dato <= 1'b0;
			canale    <= '0;
			send_data <= 1'b0;
		end else begin
			// capture strobe lasts one cycle
			load_dato <= 1'b0;
			case (state)
				link_pkg::seq_mux_en: begin
					mux_en <= 1'b1;
					state  <= link_pkg::seq_settle;
				end
				// one cycle for the analog mux to settle
				link_pkg::seq_settle: begin
					state <= link_pkg::seq_start;
				end
				link_pkg::seq_start: begin
					soc   <= 1'b1;
					state <= link_pkg::seq_wait_busy;
				end
				// converter acknowledges by raising eoc
				link_pkg::seq_wait_busy: begin
					if (eoc) begin
						state <= link_pkg::seq_wait_done;
					end
				end
				// falling eoc means the result is on data_in
				link_pkg::seq_wait_done: begin
					if (!eoc) begin
						load_dato <= 1'b1;
						soc       <= 1'b0;
						mux_en    <= 1'b0;
						canale    <= {1'b0, chan};
						send_data <= 1'b1;
						state     <= link_pkg::seq_rotate;
					end
				end
				// hold the sample until rdy has gone high and back low
				link_pkg::seq_rotate: begin
					if (rdy) begin
						rdy_seen <= 1'b1;
					end else if (rdy_seen) begin
						rdy_seen  <= 1'b0;
						send_data <= 1'b0;
						// wraps from 7 to 0 by width
						chan      <= chan + 1'b1;
						state     <= link_pkg::seq_mux_en;
					end
				end
				default: state <= link_pkg::seq_mux_en;
			endcase
		end
	end

	// sample payload, loaded together with load_dato
	always_ff @(posedge clock) begin
		if (state == link_pkg::seq_wait_done && !eoc) begin
			sample.channel <= chan;
			sample.data    <= data_in;
		end
	end

endmodule

// ==== rtl/frame_dispatcher.sv ====
// ##########################################################################
// frame dispatcher
// turns one sample into a header frame and a data frame
// and shoots them to the transmit buffer one at a time
// ##########################################################################
`timescale 1ns/1ps

module frame_dispatcher (
	input  logic                clock,
	input  logic                rst,
	input  link_pkg::sample_s   sample,
	input  logic                send_data,
	input  logic                confirm,
	output logic                rdy,
	output logic                add_mpx2,
	output link_pkg::frame_s    frame,
	output logic                shot
);

	link_pkg::disp_state_e state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= link_pkg::disp_idle;
			rdy      <= 1'b0;
			add_mpx2 <= 1'b0;
			shot     <= 1'b0;
		end else begin
			// both strobes are single cycle
			shot     <= 1'b0;
			add_mpx2 <= 1'b0;
			case (state)
				link_pkg::disp_idle: begin
					if (send_data) begin
						rdy   <= 1'b1;
						state <= link_pkg::disp_shoot;
					end
				end
				link_pkg::disp_shoot: begin
					shot  <= 1'b1;
					state <= link_pkg::disp_wait_confirm;
				end
				// the frame still held tells which of the two was confirmed
				link_pkg::disp_wait_confirm: begin
					if (confirm) begin
						if (frame.is_header) begin
							add_mpx2 <= 1'b1;
							state    <= link_pkg::disp_shoot;
						end else begin
							rdy   <= 1'b0;
							state <= link_pkg::disp_gap;
						end
					end
				end
				// lets the sequencer drop send_data before idle looks again
				link_pkg::disp_gap: begin
					state <= link_pkg::disp_idle;
				end
				default: state <= link_pkg::disp_idle;
			endcase
		end
	end

	// header is tag, a zero bit and the channel; data frame is the raw byte
	always_ff @(posedge clock) begin
		if (state == link_pkg::disp_idle && send_data) begin
			frame.payload   <= {link_pkg::header_tag, 1'b0, sample.channel};
			frame.is_header <= 1'b1;
		end else if (state == link_pkg::disp_wait_confirm && confirm && frame.is_header) begin
			frame.payload   <= sample.data;
			frame.is_header <= 1'b0;
		end
	end

endmodule

// ==== rtl/tx_buffer.sv ====
// ##########################################################################
// transmit buffer
// one frame register with load, send and confirm sequencing,
// dsr check before each send and the error flag
// ##########################################################################
`timescale 1ns/1ps

module tx_buffer (
	input  logic                  clock,
	input  logic                  rst,
	input  link_pkg::frame_s      frame,
	input  logic                  shot,
	input  logic                  dsr,
	input  logic                  tx_end,
	output link_pkg::frame_byte_t tx_byte,
	output logic                  send_en,
	output logic                  confirm,
	output logic                  error
);

	link_pkg::buf_state_e state;
	// buffer holds a frame not yet confirmed
	logic                 tre;

	always_ff @(posedge clock) begin
		if (rst) begin
			state   <= link_pkg::buf_idle;
			tre     <= 1'b0;
			send_en <= 1'b0;
			confirm <= 1'b0;
			error   <= 1'b0;
		end else begin
			send_en <= 1'b0;
			confirm <= 1'b0;
			case (state)
				link_pkg::buf_idle: begin
					if (shot && !tre) begin
						tre   <= 1'b1;
						state <= link_pkg::buf_load;
					end
				end
				link_pkg::buf_load: begin
					state <= link_pkg::buf_send;
				end
				// far end not ready: keep the frame, flag it, try again next cycle
				link_pkg::buf_send: begin
					if (tre && dsr) begin
						send_en <= 1'b1;
						error   <= 1'b0;
						state   <= link_pkg::buf_wait_end;
					end else begin
						error <= 1'b1;
					end
				end
				// frame on the line until the stop bit ends
				link_pkg::buf_wait_end: begin
					if (tx_end) begin
						confirm <= 1'b1;
						tre     <= 1'b0;
						state   <= link_pkg::buf_idle;
					end
				end
				default: state <= link_pkg::buf_idle;
			endcase
		end
	end

	// frame register
	always_ff @(posedge clock) begin
		if (state == link_pkg::buf_idle && shot && !tre) begin
			tx_byte <= frame.payload;
		end
	end

endmodule

// ==== rtl/serial_tx.sv ====
// ##########################################################################
// serial transmitter
// start bit, 8 data bits msb first, stop bit
// every bit held for bit_period clocks
// ##########################################################################
`timescale 1ns/1ps

module serial_tx #(
	parameter int bit_period = 104
) (
	input  logic                  clock,
	input  logic                  rst,
	input  link_pkg::frame_byte_t tx_byte,
	input  logic                  send_en,
	output logic                  data_out,
	output logic                  tx_end
);

	localparam int cnt_w = (bit_period > 1) ? $clog2(bit_period) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(bit_period - 1);

	link_pkg::tx_state_e   state;
	// clocks spent in the current bit
	logic [cnt_w-1:0]      cnt;
	// data bit index, 0 is the msb
	logic [2:0]            bit_idx;
	link_pkg::frame_byte_t shreg;
	logic                  bit_done;

	assign bit_done = (cnt == cnt_last);
	// last clock of the stop bit
	assign tx_end = (state == link_pkg::tx_stop) && bit_done;

	always_ff @(posedge clock) begin
		if (rst) begin
			state    <= link_pkg::tx_idle;
			cnt      <= '0;
			bit_idx  <= '0;
			data_out <= 1'b1;
		end else begin
			if (state == link_pkg::tx_idle || bit_done) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			case (state)
				// line idles high
				link_pkg::tx_idle: begin
					data_out <= 1'b1;
					if (send_en) begin
						data_out <= 1'b0;
						state    <= link_pkg::tx_start;
					end
				end
				link_pkg::tx_start: begin
					if (bit_done) begin
						bit_idx  <= '0;
						data_out <= shreg[7];
						state    <= link_pkg::tx_data;
					end
				end
				link_pkg::tx_data: begin
					if (bit_done) begin
						if (bit_idx == 3'd7) begin
							data_out <= 1'b1;
							state    <= link_pkg::tx_stop;
						end else begin
							bit_idx  <= bit_idx + 1'b1;
							data_out <= shreg[7];
						end
					end
				end
				link_pkg::tx_stop: begin
					if (bit_done) begin
						state <= link_pkg::tx_idle;
					end
				end
				default: state <= link_pkg::tx_idle;
			endcase
		end
	end

	// shift register, msb always holds the next bit to send
	always_ff @(posedge clock) begin
		if (state == link_pkg::tx_idle && send_en) begin
			shreg <= tx_byte;
		end else if (bit_done && (state == link_pkg::tx_start || state == link_pkg::tx_data)) begin
			shreg <= {shreg[6:0], 1'b0};
		end
	end

endmodule

// ==== rtl/adc_serial_link.sv ====
// ##########################################################################
// sampling link top level
// sequencer, dispatcher, transmit buffer and serial transmitter
// chained into one pipeline
// ##########################################################################
`timescale 1ns/1ps

module adc_serial_link #(
	parameter int bit_period = 104
) (
	input  logic              clock,
	input  logic              rst,
	input  logic              eoc,
	input  link_pkg::sample_t data_in,
	input  logic              dsr,
	output logic              soc,
	output logic              load_dato,
	output logic              add_mpx2,
	output logic [3:0]        canale,
	output logic              mux_en,
	output logic              error,
	output logic              data_out
);

	// sequencer to dispatcher
	link_pkg::sample_s     sample;
	logic                  send_data;
	logic                  rdy;
	// dispatcher to buffer
	link_pkg::frame_s      frame;
	logic                  shot;
	logic                  confirm;
	// buffer to transmitter
	link_pkg::frame_byte_t tx_byte;
	logic                  send_en;
	logic                  tx_end;

	adc_sequencer u_seq (
		.clock     (clock),
		.rst       (rst),
		.eoc       (eoc),
		.data_in   (data_in),
		.rdy       (rdy),
		.mux_en    (mux_en),
		.soc       (soc),
		.load_dato (load_dato),
		.canale    (canale),
		.sample    (sample),
		.send_data (send_data)
	);

	frame_dispatcher u_disp (
		.clock     (clock),
		.rst       (rst),
		.sample    (sample),
		.send_data (send_data),
		.confirm   (confirm),
		.rdy       (rdy),
		.add_mpx2  (add_mpx2),
		.frame     (frame),
		.shot      (shot)
	);

	tx_buffer u_buf (
		.clock   (clock),
		.rst     (rst),
		.frame   (frame),
		.shot    (shot),
		.dsr     (dsr),
		.tx_end  (tx_end),
		.tx_byte (tx_byte),
		.send_en (send_en),
		.confirm (confirm),
		.error   (error)
	);

	serial_tx #(
		.bit_period (bit_period)
	) u_tx (
		.clock    (clock),
		.rst      (rst),
		.tx_byte  (tx_byte),
		.send_en  (send_en),
		.data_out (data_out),
		.tx_end   (tx_end)
	);

endmodule

// ==== testbench/adc_serial_link_chk.sv ====
// ##########################################################################
// protocol checker for the transmit buffer and the serial transmitter
// concurrent assertions and their bind statements
// ##########################################################################
`timescale 1ns/1ps

module adc_serial_link_chk (
	input logic clock,
	input logic rst,
	input logic shot,
	input logic confirm,
	input logic error,
	input logic tre,
	input logic send_en,
	input logic in_flight,
	input logic tx_end,
	input logic in_stop
);

	// dispatcher waits for confirm before the next shot
	a_shot_confirm: assert property (@(posedge clock) disable iff (rst)
		!(shot && confirm)) else $error("shot and confirm high in the same cycle");

	a_error_full: assert property (@(posedge clock) disable iff (rst)
		error |-> tre) else $error("error raised with an empty buffer");

	a_send_idle: assert property (@(posedge clock) disable iff (rst)
		send_en |-> !in_flight) else $error("send_en while a frame is on the line");

	// tx_end marks the last cycle of the stop bit only
	a_end_stop: assert property (@(posedge clock) disable iff (rst)
		tx_end |-> in_stop) else $error("tx_end outside the stop bit");

endmodule

// buffer side, transmitter ports tied off
bind tx_buffer adc_serial_link_chk u_buf_chk (
	.clock     (clock),
	.rst       (rst),
	.shot      (shot),
	.confirm   (confirm),
	.error     (error),
	.tre       (tre),
	.send_en   (send_en),
	.in_flight (1'b0),
	.tx_end    (1'b0),
	.in_stop   (1'b0)
);

// transmitter side, buffer ports tied off
// stop bit means stop state with the line driven high
bind serial_tx adc_serial_link_chk u_tx_chk (
	.clock     (clock),
	.rst       (rst),
	.shot      (1'b0),
	.confirm   (1'b0),
	.error     (1'b0),
	.tre       (1'b0),
	.send_en   (send_en),
	.in_flight (state != link_pkg::tx_idle),
	.tx_end    (tx_end),
	.in_stop   (state == link_pkg::tx_stop && data_out)
);

// ==== testbench/tb_adc_serial_link.sv ====
// ##########################################################################
// testbench of the sampling link
// converter model and dsr driver fed from the stimulus file,
// line decoder with per-cycle bit checks, per-test reporting
// ##########################################################################
`timescale 1ns/1ps

module tb_adc_serial_link;

	localparam int bp             = 8;
	localparam int timeout_cycles = 500;
	localparam int max_samples    = 16;
	// selectors for wait_high
	localparam int sel_soc   = 0;
	localparam int sel_load  = 1;
	localparam int sel_error = 2;
	localparam int sel_start = 3;

	logic              clock = 1'b0;
	logic              rst;
	logic              eoc;
	link_pkg::sample_t data_in;
	logic              dsr;
	logic              soc;
	logic              load_dato;
	logic              add_mpx2;
	logic [3:0]        canale;
	logic              mux_en;
	logic              error;
	logic              data_out;

	// stimulus table, one entry per sample
	logic [7:0] s_data [0:max_samples-1];
	int         s_busy [0:max_samples-1];
	int         s_stall [0:max_samples-1];
	logic [7:0] s_hdr [0:max_samples-1];
	logic [7:0] s_dat [0:max_samples-1];
	int         sample_count = 0;

	int error_count  = 0;
	int test_count   = 0;
	int failed_tests = 0;
	// add_mpx2 pulses seen so far
	int mpx_count    = 0;

	adc_serial_link #(
		.bit_period (bp)
	) u_dut (
		.clock     (clock),
		.rst       (rst),
		.eoc       (eoc),
		.data_in   (data_in),
		.dsr       (dsr),
		.soc       (soc),
		.load_dato (load_dato),
		.add_mpx2  (add_mpx2),
		.canale    (canale),
		.mux_en    (mux_en),
		.error     (error),
		.data_out  (data_out)
	);

	always #5 clock = ~clock;

	always @(negedge clock) begin
		if (add_mpx2 === 1'b1) begin
			mpx_count <= mpx_count + 1;
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s expected %0h actual %0h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		if (error_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: not ok", name);
			failed_tests++;
		end
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			sel_soc:   return soc;
			sel_load:  return load_dato;
			sel_error: return error;
			default:   return !data_out;
		endcase
	endfunction

	// polls on the falling clock edge, where DUT outputs are settled
	task automatic wait_high(input int sel, input string what);
		int n;
		n = 0;
		@(negedge clock);
		while (probe(sel) !== 1'b1) begin
			n++;
			if (n > timeout_cycles) begin
				abort_run({"timeout waiting for ", what});
			end
			@(negedge clock);
		end
	endtask

	task automatic load_stimulus();
		int         fd;
		int         n;
		int         c;
		logic [7:0] v_data;
		logic [7:0] v_hdr;
		logic [7:0] v_dat;
		int         v_busy;
		int         v_stall;
		fd = $fopen("testbench/link_input.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the stimulus file testbench/link_input.txt");
		end else begin
			while (!$feof(fd) && sample_count < max_samples) begin
				n = $fscanf(fd, "%h %d %d %h %h\n", v_data, v_busy, v_stall, v_hdr, v_dat);
				if (n == 5) begin
					s_data[sample_count]  = v_data;
					s_busy[sample_count]  = v_busy;
					s_stall[sample_count] = v_stall;
					s_hdr[sample_count]   = v_hdr;
					s_dat[sample_count]   = v_dat;
					sample_count++;
				end else begin
					// comment line, skip to its end
					c = $fgetc(fd);
					while (c != 10 && c != -1) begin
						c = $fgetc(fd);
					end
				end
			end
			$fclose(fd);
			if (sample_count != 12) begin
				abort_run("stimulus file does not hold 12 samples");
			end
		end
	endtask

	// optional dsr stall, then one frame decoded and compared cycle by cycle
	task automatic take_frame(input int stall, input logic [7:0] expected,
			input int mpx_expected, input string name);
		logic [10*bp-1:0] line;
		logic [9:0]       bits;
		logic [7:0]       got;
		int               j;
		int               misses;
		if (stall > 0) begin
			@(posedge clock);
			dsr <= 1'b0;
			wait_high(sel_error, "error while dsr is low");
			repeat (stall) begin
				@(negedge clock);
				check_value({name, " error while stalled"}, 1, error);
				check_value({name, " line while stalled"}, 1, data_out);
			end
			@(posedge clock);
			dsr <= 1'b1;
		end
		wait_high(sel_start, {name, " start bit"});
		check_value({name, " error at start"}, 0, error);
		check_value({name, " add_mpx2 pulses"}, mpx_expected, mpx_count);
		line[0] = data_out;
		for (j = 1; j < 10 * bp; j++) begin
			@(negedge clock);
			line[j] = data_out;
		end
		// start bit, byte msb first, stop bit
		bits   = {1'b0, expected, 1'b1};
		misses = 0;
		for (j = 0; j < 10 * bp; j++) begin
			if (line[j] !== bits[9 - j / bp]) begin
				misses++;
			end
		end
		check_value({name, " cycles off the bit grid"}, 0, misses);
		got = '0;
		for (j = 1; j <= 8; j++) begin
			got = {got[6:0], line[j * bp + bp / 2]};
		end
		check_value({name, " start bit"}, 0, line[bp / 2]);
		check_value({name, " stop bit"}, 1, line[9 * bp + bp / 2]);
		check_value({name, " byte"}, expected, got);
	endtask

	task automatic run_sample(input int idx);
		logic [3:0] chan;
		int         base;
		int         errs_before;
		string      tag;
		errs_before = error_count;
		tag = $sformatf("sample %0d", idx);
		// converter model: busy on the edge after soc, result with falling eoc
		wait_high(sel_soc, {tag, " soc"});
		check_value({tag, " mux_en at soc"}, 1, mux_en);
		@(posedge clock);
		eoc <= 1'b1;
		repeat (s_busy[idx]) @(posedge clock);
		eoc     <= 1'b0;
		data_in <= s_data[idx];
		wait_high(sel_load, {tag, " load_dato"});
		chan = canale;
		check_value({tag, " canale"}, idx % 8, chan);
		check_value({tag, " canale msb"}, 0, chan[3]);
		check_value({tag, " header channel field"}, s_hdr[idx][2:0], chan[2:0]);
		// one add_mpx2 for every sample before this one
		base = idx;
		take_frame(s_stall[idx], s_hdr[idx], base, {tag, " header"});
		check_value({tag, " add_mpx2 before header end"}, base, mpx_count);
		take_frame(s_stall[idx], s_dat[idx], base + 1, {tag, " data"});
		check_value({tag, " add_mpx2 per sample"}, base + 1, mpx_count);
		report_test(tag, errs_before);
	endtask

	initial begin
		int i;
		int errs_before;
		rst     = 1'b1;
		eoc     = 1'b0;
		data_in = '0;
		dsr     = 1'b1;
		load_stimulus();
		errs_before = error_count;
		// reset held for 10 edges, last check falls just after release
		for (i = 0; i < 10; i++) begin
			@(posedge clock);
			if (i == 9) begin
				rst <= 1'b0;
			end
			@(negedge clock);
			check_value("reset data_out", 1, data_out);
			check_value("reset soc", 0, soc);
			check_value("reset mux_en", 0, mux_en);
			check_value("reset load_dato", 0, load_dato);
			check_value("reset add_mpx2", 0, add_mpx2);
			check_value("reset error", 0, error);
			check_value("reset canale", 0, canale);
		end
		report_test("reset", errs_before);
		for (i = 0; i < sample_count; i++) begin
			run_sample(i);
		end
		$display("%0d tests, %0d failed, %0d check errors", test_count, failed_tests,
			error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== testbench/link_input.txt ====
# columns: data byte (hex), eoc busy cycles, dsr low cycles before each frame,
# expected header byte (hex), expected data byte (hex); channels rotate from 0
3c 1 0 a0 3c
a5 2 3 a1 a5
00 3 0 a2 00
ff 1 1 a3 ff
5a 4 0 a4 5a
81 2 5 a5 81
7e 5 0 a6 7e
c3 1 2 a7 c3
01 6 0 a0 01
80 2 4 a1 80
96 3 0 a2 96
69 1 1 a3 69

// ==== src.f ====
rtl/link_pkg.sv
rtl/adc_sequencer.sv
rtl/frame_dispatcher.sv
rtl/tx_buffer.sv
rtl/serial_tx.sv
rtl/adc_serial_link.sv
testbench/adc_serial_link_chk.sv
testbench/tb_adc_serial_link.sv
